// ==== Bender.yml ====
package:
  name: icache_refill

sources:
  - include_dirs:
      - .
    files:
      - icache_refill_pkg.sv
      - refill_ctrl.sv
      - refill_ack_collector.sv
      - way_select_lfsr.sv
      - icache_store.sv
      - icache_refill_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - icache_refill_checker.sv
      - icache_refill_asserts.sv
      - tb_icache_refill.sv

// ==== icache_refill.f ====
+incdir+.
icache_refill_pkg.sv
refill_ctrl.sv
refill_ack_collector.sv
way_select_lfsr.sv
icache_store.sv
icache_refill_top.sv
icache_refill_checker.sv
icache_refill_asserts.sv
tb_icache_refill.sv

// ==== icache_refill_asserts.sv ====
`timescale 1ns/1ps
`include "icache_refill_config.svh"

module icache_refill_asserts (
	input logic                     clk,
	input logic                     rst,
	input logic                     miss_ready,
	input logic                     mem_req_valid,
	input logic                     mem_req_ready,
	input icache_refill_pkg::addr_t mem_req_adr,
	input icache_refill_pkg::tid_t  mem_req_tid,
	input logic                     alloc_valid,
	input icache_refill_pkg::slot_t alloc_slot,
	input logic                     free_valid,
	input icache_refill_pkg::slot_t free_slot
);

	int fail_count = 0;
	// Slots handed out and not yet released, rebuilt from the alloc and free pulses
	logic [`SLOTS-1:0] owned;

	always_ff @(posedge clk) begin
		if (rst) begin
			owned <= '0;
		end else begin
			if (free_valid)
				owned[free_slot] <= 1'b0;
			if (alloc_valid)
				owned[alloc_slot] <= 1'b1;
		end
	end

	// A stalled request keeps its address and tid
	req_stable: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid && !mem_req_ready |=>
			mem_req_valid && $stable(mem_req_adr) && $stable(mem_req_tid))
		else begin
			fail_count++;
			$error("Memory request changed while stalled");
		end

	// A slot is never handed out again before its line is released
	no_reuse: assert property (@(posedge clk) disable iff (rst)
		alloc_valid |-> !owned[alloc_slot])
		else begin
			fail_count++;
			$error("Busy slot allocated again");
		end

	// With every slot held no new miss may be taken
	full_blocks: assert property (@(posedge clk) disable iff (rst)
		(&owned) |-> !miss_ready)
		else begin
			fail_count++;
			$error("Miss accepted while every slot is busy");
		end

endmodule

bind refill_ctrl icache_refill_asserts u_asserts (
	.clk(clk), .rst(rst), .miss_ready(miss_ready),
	.mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
	.mem_req_adr(mem_req_adr), .mem_req_tid(mem_req_tid),
	.alloc_valid(alloc_valid), .alloc_slot(alloc_slot),
	.free_valid(free_valid), .free_slot(free_slot)
);

// ==== icache_refill_checker.sv ====
`timescale 1ns/1ps
`include "icache_refill_config.svh"

module icache_refill_checker (
	input logic                     clk,
	input logic                     rst,
	input logic                     miss_valid,
	input logic                     miss_ready,
	input icache_refill_pkg::addr_t miss_padr,
	input logic                     mem_req_valid,
	input logic                     mem_req_ready,
	input icache_refill_pkg::addr_t mem_req_adr,
	input icache_refill_pkg::tid_t  mem_req_tid,
	input logic                     lookup_valid,
	input logic                     hit,
	input icache_refill_pkg::line_t hit_line,
	input logic                     exp_en,
	input logic                     exp_hit,
	input icache_refill_pkg::line_t exp_line
);

	int errors = 0;
	int passed = 0;
	int failed = 0;
	int start_errors = 0;
	// Physical addresses of accepted misses still owed requests
	icache_refill_pkg::addr_t pq[$];
	int nbeat = 0;
	icache_refill_pkg::slot_t first_slot;
	icache_refill_pkg::addr_t exp_adr;
	logic lk_pend = 1'b0;
	logic lk_hit;
	icache_refill_pkg::line_t lk_line;

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("Mismatch %s: got %h expected %h", name, got, want);
			errors++;
		end
	endtask

	// Request beat n carries the miss address with bits 3:2 set to n
	task automatic check_request();
		if (pq.size() == 0) begin
			$display("Memory request seen without an accepted miss");
			errors++;
			return;
		end
		exp_adr = pq[0];
		exp_adr[3:2] = nbeat[1:0];
		if (mem_req_adr !== exp_adr) begin
			$display("Mismatch mem_req_adr: got %h expected %h", mem_req_adr, exp_adr);
			errors++;
		end
		if (nbeat == 0)
			first_slot = mem_req_tid[3:2];
		if (mem_req_tid !== {first_slot, nbeat[1:0]}) begin
			$display("Mismatch mem_req_tid: got %h expected %h",
				mem_req_tid, {first_slot, nbeat[1:0]});
			errors++;
		end
		nbeat++;
		if (nbeat == 4) begin
			nbeat = 0;
			void'(pq.pop_front());
		end
	endtask

	// Everything is sampled at the falling edge where all signals are settled
	always @(negedge clk) begin
		if (!rst) begin
			if (lk_pend) begin
				check_bit("hit", hit, lk_hit);
				if (lk_hit && hit === 1'b1 && hit_line !== lk_line) begin
					$display("Mismatch hit_line: got %h expected %h", hit_line, lk_line);
					errors++;
				end
			end
			lk_pend = lookup_valid && exp_en;
			lk_hit = exp_hit;
			lk_line = exp_line;
			if (miss_valid && miss_ready)
				pq.push_back(miss_padr);
			if (mem_req_valid && mem_req_ready)
				check_request();
		end
	end

	task automatic end_test(input string name);
		if (errors == start_errors) begin
			$display("PASS %s", name);
			passed++;
		end else begin
			$display("FAIL %s", name);
			failed++;
		end
		start_errors = errors;
	endtask

	task automatic summary();
		if (pq.size() != 0) begin
			$display("A miss ended with fewer than four memory requests");
			errors++;
		end
		$display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
	endtask

endmodule

// ==== icache_refill_config.svh ====
`ifndef ICACHE_REFILL_CONFIG_SVH
`define ICACHE_REFILL_CONFIG_SVH

// ==============================
// Base sizes
// ==============================

// Width of a byte address on every channel
`define ADDR_W 32
// Width of one memory beat, one instruction word
`define BEAT_W 32
// Beats that make up one cache line, four words or 16 bytes
`define BEATS 4
// Outstanding refill transactions the controller can track
`define SLOTS 4
// Cache geometry, sets are picked by virtual address bits 7:4
`define SETS 16
`define WAYS 2

// ==============================
// Derived widths
// ==============================

// Byte offset inside a line
`define OFS_W $clog2(`BEATS * `BEAT_W / 8)
`define SET_W $clog2(`SETS)
`define SLOT_W $clog2(`SLOTS)
`define BIDX_W $clog2(`BEATS)
`define WAY_W $clog2(`WAYS)

`endif

// ==== icache_refill_input.txt ====
# Columns: vadr padr order beat0 beat1 beat2 beat3, all hex
# Order nibbles from the left give the beat response order
00012000 80040000 0123 11110000 11110001 11110002 11110003
00012010 80040110 3210 22220000 22220001 22220002 22220003
00034020 80050220 2031 33330000 33330001 33330002 33330003
00034030 80050330 1302 44440000 44440001 44440002 44440003
00056040 80060440 0321 55550000 55550001 55550002 55550003
00056050 80060550 3012 66660000 66660001 66660002 66660003
00078060 80070660 1230 77770000 77770001 77770002 77770003
00078070 80070770 2103 88880000 88880001 88880002 88880003
0009a080 80080880 3120 99990000 99990001 99990002 99990003
0009a090 80080990 0213 aaaa0000 aaaa0001 aaaa0002 aaaa0003

// ==== icache_refill_pkg.sv ====
`include "icache_refill_config.svh"

package icache_refill_pkg;

	// Full byte address, virtual or physical
	typedef logic [`ADDR_W-1:0] addr_t;

	// One memory beat
	typedef logic [`BEAT_W-1:0] beat_t;

	// A whole cache line, beat 0 sits in the low bits
	typedef logic [`BEATS*`BEAT_W-1:0] line_t;

	// Address bits above the set index
	typedef logic [`ADDR_W-`SET_W-`OFS_W-1:0] tag_t;

	// Transaction slot number and beat number inside a line
	typedef logic [`SLOT_W-1:0] slot_t;
	typedef logic [`BIDX_W-1:0] beat_idx_t;

	// Transaction id, slot in the upper bits and beat in the lower bits
	typedef logic [`SLOT_W+`BIDX_W-1:0] tid_t;

	typedef logic [`WAY_W-1:0] way_t;
	typedef logic [`SET_W-1:0] set_t;

	// Refill controller states
	typedef enum logic {
		IDLE,
		ISSUE
	} ctrl_state_t;

endpackage

// ==== icache_refill_top.sv ====
`timescale 1ns/1ps

module icache_refill_top (
	input  logic                     clk,
	input  logic                     rst,
	// Miss channel
	input  logic                     miss_valid,
	input  icache_refill_pkg::addr_t miss_vadr,
	input  icache_refill_pkg::addr_t miss_padr,
	output logic                     miss_ready,
	// Memory request channel
	output logic                     mem_req_valid,
	output icache_refill_pkg::addr_t mem_req_adr,
	output icache_refill_pkg::tid_t  mem_req_tid,
	input  logic                     mem_req_ready,
	// Memory responses, always accepted
	input  logic                     mem_resp_valid,
	input  icache_refill_pkg::tid_t  mem_resp_tid,
	input  icache_refill_pkg::addr_t mem_resp_adr,
	input  icache_refill_pkg::beat_t mem_resp_data,
	// Lookup port
	input  logic                     lookup_valid,
	input  icache_refill_pkg::addr_t lookup_vadr,
	output logic                     hit,
	output icache_refill_pkg::line_t hit_line
);

	// Controller to collector
	logic alloc_valid;
	icache_refill_pkg::slot_t alloc_slot;
	icache_refill_pkg::addr_t alloc_vadr;
	// Collector back to controller
	logic free_valid;
	icache_refill_pkg::slot_t free_slot;
	// Collector to store
	logic fill_valid;
	icache_refill_pkg::addr_t fill_vadr;
	icache_refill_pkg::tag_t fill_ptag;
	icache_refill_pkg::line_t fill_line;
	icache_refill_pkg::way_t fill_way;
	icache_refill_pkg::way_t lfsr_value;

	refill_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.miss_valid(miss_valid), .miss_vadr(miss_vadr), .miss_padr(miss_padr),
		.miss_ready(miss_ready),
		.mem_req_valid(mem_req_valid), .mem_req_adr(mem_req_adr),
		.mem_req_tid(mem_req_tid), .mem_req_ready(mem_req_ready),
		.alloc_valid(alloc_valid), .alloc_slot(alloc_slot), .alloc_vadr(alloc_vadr),
		.free_valid(free_valid), .free_slot(free_slot)
	);

	refill_ack_collector u_collector (
		.clk(clk), .rst(rst),
		.mem_resp_valid(mem_resp_valid), .mem_resp_tid(mem_resp_tid),
		.mem_resp_adr(mem_resp_adr), .mem_resp_data(mem_resp_data),
		.alloc_valid(alloc_valid), .alloc_slot(alloc_slot), .alloc_vadr(alloc_vadr),
		.lfsr_value(lfsr_value),
		.fill_valid(fill_valid), .fill_vadr(fill_vadr), .fill_ptag(fill_ptag),
		.fill_line(fill_line), .fill_way(fill_way),
		.free_valid(free_valid), .free_slot(free_slot)
	);

	way_select_lfsr u_lfsr (
		.clk(clk), .rst(rst),
		.value(lfsr_value)
	);

	icache_store u_store (
		.clk(clk), .rst(rst),
		.fill_valid(fill_valid), .fill_vadr(fill_vadr), .fill_ptag(fill_ptag),
		.fill_line(fill_line), .fill_way(fill_way),
		.lookup_valid(lookup_valid), .lookup_vadr(lookup_vadr),
		.hit(hit), .hit_line(hit_line)
	);

endmodule

// ==== icache_store.sv ====
`timescale 1ns/1ps
`include "icache_refill_config.svh"

module icache_store (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     fill_valid,
	input  icache_refill_pkg::addr_t fill_vadr,
	input  icache_refill_pkg::tag_t  fill_ptag,
	input  icache_refill_pkg::line_t fill_line,
	input  icache_refill_pkg::way_t  fill_way,
	input  logic                     lookup_valid,
	input  icache_refill_pkg::addr_t lookup_vadr,
	output logic                     hit,
	output icache_refill_pkg::line_t hit_line
);

	// ==============================
	// Arrays
	// ==============================

	logic [`WAYS-1:0] valid [`SETS];
	icache_refill_pkg::tag_t vtag_mem [`SETS][`WAYS];
	// Physical tags are stored with each line for later coherence work
	icache_refill_pkg::tag_t ptag_mem [`SETS][`WAYS];
	icache_refill_pkg::line_t data_mem [`SETS][`WAYS];

	// Sets are indexed by virtual address bits 7:4
	icache_refill_pkg::set_t fill_set;
	icache_refill_pkg::set_t look_set;
	icache_refill_pkg::tag_t look_tag;
	logic hit_d;
	icache_refill_pkg::line_t line_d;

	assign fill_set = fill_vadr[`SET_W+`OFS_W-1:`OFS_W];
	assign look_set = lookup_vadr[`SET_W+`OFS_W-1:`OFS_W];
	assign look_tag = lookup_vadr[`ADDR_W-1:`SET_W+`OFS_W];

	// Write the completed line into the chosen way
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `SETS; s++)
				valid[s] <= '0;
		end else if (fill_valid) begin
			valid[fill_set][fill_way] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_valid) begin
			vtag_mem[fill_set][fill_way] <= fill_vadr[`ADDR_W-1:`SET_W+`OFS_W];
			ptag_mem[fill_set][fill_way] <= fill_ptag;
			data_mem[fill_set][fill_way] <= fill_line;
		end
	end

	// ==============================
	// Lookup
	// ==============================

	// Compare the virtual tag in every way of the set
	always_comb begin
		hit_d = 1'b0;
		line_d = '0;
		for (int w = 0; w < `WAYS; w++) begin
			if (valid[look_set][w] && vtag_mem[look_set][w] == look_tag) begin
				hit_d = 1'b1;
				line_d = data_mem[look_set][w];
			end
		end
	end

	// Result appears exactly one cycle after the request
	always_ff @(posedge clk) begin
		if (rst)
			hit <= 1'b0;
		else
			hit <= lookup_valid && hit_d;
	end

	always_ff @(posedge clk)
		hit_line <= line_d;

endmodule

// ==== refill_ack_collector.sv ====
`timescale 1ns/1ps
`include "icache_refill_config.svh"

module refill_ack_collector (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     mem_resp_valid,
	input  icache_refill_pkg::tid_t  mem_resp_tid,
	input  icache_refill_pkg::addr_t mem_resp_adr,
	input  icache_refill_pkg::beat_t mem_resp_data,
	input  logic                     alloc_valid,
	input  icache_refill_pkg::slot_t alloc_slot,
	input  icache_refill_pkg::addr_t alloc_vadr,
	input  icache_refill_pkg::way_t  lfsr_value,
	output logic                     fill_valid,
	output icache_refill_pkg::addr_t fill_vadr,
	output icache_refill_pkg::tag_t  fill_ptag,
	output icache_refill_pkg::line_t fill_line,
	output icache_refill_pkg::way_t  fill_way,
	output logic                     free_valid,
	output icache_refill_pkg::slot_t free_slot
);

	// Per-slot assembly buffers
	icache_refill_pkg::addr_t vadr_buf [`SLOTS];
	icache_refill_pkg::tag_t ptag_buf [`SLOTS];
	icache_refill_pkg::line_t line_buf [`SLOTS];
	// One bit per beat that has arrived for each slot
	logic [`BEATS-1:0] present [`SLOTS];
	// Decoded response fields
	icache_refill_pkg::slot_t resp_slot;
	icache_refill_pkg::beat_idx_t resp_beat;
	// Completion scan result
	logic done_any;
	icache_refill_pkg::slot_t done_slot;

	// ==============================
	// Response decode
	// ==============================

	// The slot travels in the upper tid bits
	assign resp_slot = mem_resp_tid[`SLOT_W+`BIDX_W-1:`BIDX_W];
	// The beat is taken from the address, bits 3:2
	assign resp_beat = mem_resp_adr[`OFS_W-1:`OFS_W-`BIDX_W];

	// Lowest slot with every beat present goes first
	always_comb begin
		done_any = 1'b0;
		done_slot = '0;
		for (int i = `SLOTS - 1; i >= 0; i--) begin
			if (&present[i]) begin
				done_any = 1'b1;
				done_slot = icache_refill_pkg::slot_t'(i);
			end
		end
	end

	// ==============================
	// Line assembly and emit
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			fill_valid <= 1'b0;
			free_valid <= 1'b0;
			for (int i = 0; i < `SLOTS; i++)
				present[i] <= '0;
		end else begin
			// Memory cannot be stalled, so each beat is recorded as it comes
			if (mem_resp_valid)
				present[resp_slot][resp_beat] <= 1'b1;
			fill_valid <= done_any;
			free_valid <= done_any;
			// A finished slot is emptied once its line leaves
			if (done_any)
				present[done_slot] <= '0;
		end
	end

	// Payload registers carry no reset, they are qualified by the pulses
	always_ff @(posedge clk) begin
		if (alloc_valid)
			vadr_buf[alloc_slot] <= alloc_vadr;
		if (mem_resp_valid) begin
			line_buf[resp_slot][resp_beat*`BEAT_W +: `BEAT_W] <= mem_resp_data;
			// Every beat of a line carries the same physical tag
			ptag_buf[resp_slot] <= mem_resp_adr[`ADDR_W-1:`SET_W+`OFS_W];
		end
		if (done_any) begin
			fill_vadr <= vadr_buf[done_slot];
			fill_ptag <= ptag_buf[done_slot];
			fill_line <= line_buf[done_slot];
			// Victim way is whatever the LFSR shows this cycle
			fill_way <= lfsr_value;
			free_slot <= done_slot;
		end
	end

endmodule

// ==== refill_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_refill_config.svh"

module refill_ctrl (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     miss_valid,
	input  icache_refill_pkg::addr_t miss_vadr,
	input  icache_refill_pkg::addr_t miss_padr,
	output logic                     miss_ready,
	output logic                     mem_req_valid,
	output icache_refill_pkg::addr_t mem_req_adr,
	output icache_refill_pkg::tid_t  mem_req_tid,
	input  logic                     mem_req_ready,
	output logic                     alloc_valid,
	output icache_refill_pkg::slot_t alloc_slot,
	output icache_refill_pkg::addr_t alloc_vadr,
	input  logic                     free_valid,
	input  icache_refill_pkg::slot_t free_slot
);

	// One bit per transaction slot, set while its line is in flight
	logic [`SLOTS-1:0] busy;
	icache_refill_pkg::ctrl_state_t state;
	icache_refill_pkg::beat_idx_t beat;
	// Captured miss, held for all four beat requests
	icache_refill_pkg::addr_t req_padr;
	icache_refill_pkg::slot_t req_slot;
	// Lowest free slot
	logic pick_ok;
	icache_refill_pkg::slot_t pick_slot;

	// ==============================
	// Slot allocation
	// ==============================

	// Scan downward so the lowest free slot is the one left standing
	always_comb begin
		pick_ok = 1'b0;
		pick_slot = '0;
		for (int i = `SLOTS - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				pick_ok = 1'b1;
				pick_slot = icache_refill_pkg::slot_t'(i);
			end
		end
	end

	// A new miss only fits while no requests are being issued
	assign miss_ready = (state == icache_refill_pkg::IDLE) && pick_ok;
	assign alloc_valid = miss_valid && miss_ready;
	assign alloc_slot = pick_slot;
	assign alloc_vadr = miss_vadr;

	// ==============================
	// Beat request issue
	// ==============================

	assign mem_req_valid = (state == icache_refill_pkg::ISSUE);
	// Line address with the beat number dropped into bits 3:2
	assign mem_req_adr = {req_padr[`ADDR_W-1:`OFS_W], beat, req_padr[`OFS_W-`BIDX_W-1:0]};
	assign mem_req_tid = {req_slot, beat};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= icache_refill_pkg::IDLE;
			beat <= '0;
			busy <= '0;
		end else begin
			// Allocation and release never hit the same slot in one cycle
			if (alloc_valid)
				busy[pick_slot] <= 1'b1;
			if (free_valid)
				busy[free_slot] <= 1'b0;
			case (state)
				icache_refill_pkg::IDLE: begin
					beat <= '0;
					if (alloc_valid)
						state <= icache_refill_pkg::ISSUE;
				end
				icache_refill_pkg::ISSUE: begin
					// Advance only when memory takes the request
					if (mem_req_ready) begin
						beat <= beat + 1'b1;
						if (beat == icache_refill_pkg::beat_idx_t'(`BEATS - 1))
							state <= icache_refill_pkg::IDLE;
					end
				end
				default: state <= icache_refill_pkg::IDLE;
			endcase
		end
	end

	// Miss payload, only meaningful once the slot is in ISSUE
	always_ff @(posedge clk) begin
		if (alloc_valid) begin
			req_padr <= miss_padr;
			req_slot <= pick_slot;
		end
	end

endmodule

// ==== tb_icache_refill.sv ====
`timescale 1ns/1ps
`include "icache_refill_config.svh"

module tb_icache_refill;

	localparam int MAX_T = 16;
	localparam int TMO = 400;

	logic clk;
	logic rst;
	logic miss_valid;
	icache_refill_pkg::addr_t miss_vadr;
	icache_refill_pkg::addr_t miss_padr;
	logic miss_ready;
	logic mem_req_valid;
	icache_refill_pkg::addr_t mem_req_adr;
	icache_refill_pkg::tid_t mem_req_tid;
	logic mem_req_ready;
	logic mem_resp_valid;
	icache_refill_pkg::tid_t mem_resp_tid;
	icache_refill_pkg::addr_t mem_resp_adr;
	icache_refill_pkg::beat_t mem_resp_data;
	logic lookup_valid;
	icache_refill_pkg::addr_t lookup_vadr;
	logic hit;
	icache_refill_pkg::line_t hit_line;
	// Expected lookup result handed to the checker
	logic exp_en;
	logic exp_hit;
	icache_refill_pkg::line_t exp_line;

	// Stimulus table loaded from the data file
	icache_refill_pkg::addr_t t_vadr [MAX_T];
	icache_refill_pkg::addr_t t_padr [MAX_T];
	logic [15:0] t_order [MAX_T];
	icache_refill_pkg::beat_t t_beat [MAX_T][4];
	int n_tests;
	// Accepted misses waiting for their requests, and responses not yet sent
	int miss_q[$];
	logic [67:0] resp_q[$];
	logic hold_resp;

	icache_refill_top DUT (.*);

	icache_refill_checker chk (
		.clk(clk), .rst(rst), .miss_valid(miss_valid), .miss_ready(miss_ready),
		.miss_padr(miss_padr), .mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready), .mem_req_adr(mem_req_adr),
		.mem_req_tid(mem_req_tid), .lookup_valid(lookup_valid), .hit(hit),
		.hit_line(hit_line), .exp_en(exp_en), .exp_hit(exp_hit), .exp_line(exp_line)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("Run aborted: %s", why);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic read_stimulus();
		int fd;
		int cnt;
		string line;
		icache_refill_pkg::addr_t va;
		icache_refill_pkg::addr_t pa;
		logic [15:0] oc;
		icache_refill_pkg::beat_t b0, b1, b2, b3;
		n_tests = 0;
		fd = $fopen("icache_refill_input.txt", "r");
		if (fd == 0)
			abort_run("cannot open icache_refill_input.txt");
		while (!$feof(fd) && n_tests < MAX_T) begin
			cnt = $fgets(line, fd);
			// Lines starting with a hash are column notes
			if (cnt > 0 && line.len() > 8 && line[0] != 8'h23) begin
				cnt = $sscanf(line, "%h %h %h %h %h %h %h", va, pa, oc, b0, b1, b2, b3);
				if (cnt == 7) begin
					t_vadr[n_tests] = va;
					t_padr[n_tests] = pa;
					t_order[n_tests] = oc;
					t_beat[n_tests][0] = b0;
					t_beat[n_tests][1] = b1;
					t_beat[n_tests][2] = b2;
					t_beat[n_tests][3] = b3;
					n_tests++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic wait_miss_ready();
		int i;
		for (i = 0; i < TMO; i++) begin
			@(negedge clk);
			if (miss_ready)
				break;
		end
		if (i == TMO)
			abort_run("miss_ready never went high");
	endtask

	// Returns once the controller has no request left to present
	task automatic wait_req_idle();
		int i;
		for (i = 0; i < TMO; i++) begin
			@(negedge clk);
			if (!mem_req_valid)
				break;
		end
		if (i == TMO)
			abort_run("memory requests never finished");
	endtask

	task automatic issue_miss(input int t);
		@(posedge clk);
		#2;
		miss_valid = 1'b1;
		miss_vadr = t_vadr[t];
		miss_padr = t_padr[t];
		wait_miss_ready();
		miss_q.push_back(t);
		@(posedge clk);
		#2;
		miss_valid = 1'b0;
	endtask

	// One lookup, result visible at the negedge after the next rising edge
	task automatic lookup(input int t, input logic en, input logic eh);
		@(posedge clk);
		#2;
		lookup_valid = 1'b1;
		lookup_vadr = t_vadr[t];
		exp_en = en;
		exp_hit = eh;
		exp_line = {t_beat[t][3], t_beat[t][2], t_beat[t][1], t_beat[t][0]};
		@(posedge clk);
		#2;
		lookup_valid = 1'b0;
		exp_en = 1'b0;
		@(negedge clk);
	endtask

	task automatic check_line(input int t);
		int i;
		for (i = 0; i < TMO; i++) begin
			lookup(t, 1'b0, 1'b0);
			if (hit)
				break;
		end
		if (i == TMO)
			abort_run($sformatf("line of miss %0d never reached the cache", t));
		lookup(t, 1'b1, 1'b1);
		chk.end_test($sformatf("miss %0d", t));
	endtask

	// ==============================
	// Memory model
	// ==============================

	// Collect the four requests of a miss, then queue its responses
	initial begin
		int cnt;
		int t;
		int pos;
		int b;
		icache_refill_pkg::addr_t radr [4];
		icache_refill_pkg::tid_t rtid [4];
		cnt = 0;
		forever begin
			@(negedge clk);
			if (!rst && mem_req_valid && mem_req_ready) begin
				b = mem_req_tid[1:0];
				radr[b] = mem_req_adr;
				rtid[b] = mem_req_tid;
				cnt++;
				if (cnt == 4) begin
					if (miss_q.size() == 0)
						abort_run("memory requests arrived without an accepted miss");
					cnt = 0;
					t = miss_q.pop_front();
					pos = 0;
					// Order code nibbles from the top give the beat order, and
					// random insert points interleave with other slots
					for (int k = 3; k >= 0; k--) begin
						b = t_order[t][k*4 +: 2];
						pos = pos + ($urandom % (resp_q.size() - pos + 1));
						resp_q.insert(pos, {rtid[b], radr[b], t_beat[t][b]});
						pos++;
					end
				end
			end
		end
	end

	// Random request stalls and response gaps
	initial begin
		logic [67:0] e;
		forever begin
			@(posedge clk);
			#2;
			mem_req_ready = ($urandom % 4) != 0;
			if (!hold_resp && resp_q.size() > 0 && ($urandom % 3) != 0) begin
				e = resp_q.pop_front();
				mem_resp_valid = 1'b1;
				mem_resp_tid = e[67:64];
				mem_resp_adr = e[63:32];
				mem_resp_data = e[31:0];
			end else begin
				mem_resp_valid = 1'b0;
			end
		end
	end

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		void'($urandom(32'h4c3662d5));
		rst = 1'b1;
		miss_valid = 1'b0;
		miss_vadr = '0;
		miss_padr = '0;
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_tid = '0;
		mem_resp_adr = '0;
		mem_resp_data = '0;
		lookup_valid = 1'b0;
		lookup_vadr = '0;
		exp_en = 1'b0;
		exp_hit = 1'b0;
		exp_line = '0;
		hold_resp = 1'b0;
		read_stimulus();
		if (n_tests < 10)
			abort_run("data file holds fewer than ten misses");
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		// Empty cache after reset
		wait_miss_ready();
		chk.check_bit("mem_req_valid", mem_req_valid, 1'b0);
		for (int t = 0; t < n_tests; t++)
			lookup(t, 1'b1, 1'b0);
		chk.end_test("reset state");

		// Several misses in flight with interleaved responses
		for (int t = 0; t < 6; t++) begin
			issue_miss(t);
			repeat ($urandom % 3) @(posedge clk);
		end
		for (int t = 0; t < 6; t++)
			check_line(t);

		// Fill every slot while memory stays silent
		hold_resp = 1'b1;
		for (int t = 6; t < 10; t++)
			issue_miss(t);
		// Only the full slot table can hold miss_ready low from here on
		wait_req_idle();
		repeat (8) begin
			@(negedge clk);
			chk.check_bit("miss_ready", miss_ready, 1'b0);
		end
		hold_resp = 1'b0;
		wait_miss_ready();
		chk.end_test("slots full");
		for (int t = 6; t < 10; t++)
			check_line(t);

		chk.summary();
		if (chk.errors == 0 && DUT.u_ctrl.u_asserts.fail_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== way_select_lfsr.sv ====
`timescale 1ns/1ps

module way_select_lfsr (
	input  logic                    clk,
	input  logic                    rst,
	output icache_refill_pkg::way_t value
);

	// Any nonzero start works, the all-zero state would lock up
	localparam logic [16:0] SEED = 17'h0ace1;

	logic [16:0] lfsr;
	logic feedback;

	// Taps at 17 and 14 give the maximal period of 2^17 - 1
	assign feedback = lfsr[16] ^ lfsr[13];

	// Runs every cycle so fills see a fresh way
	always_ff @(posedge clk) begin
		if (rst)
			lfsr <= SEED;
		else
			lfsr <= {lfsr[15:0], feedback};
	end

	// Low bits choose the victim
	assign value = lfsr[$bits(icache_refill_pkg::way_t)-1:0];

endmodule
